//--- run.sh
#!/usr/bin/env bash
# build and run the core testbench, exit status is the simulation result
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -f sim.f --top-module coreTb -Mdir obj_dir \
	&& ./obj_dir/VcoreTb \
	|| { echo "simulation failed"; exit 1; }

//--- sim.f
+incdir+verif
source/mipsPkg.sv
source/stageReg.sv
source/controlDecoder.sv
source/registerFile.sv
source/alu.sv
source/hazardUnit.sv
source/datapath.sv
source/mipsCore.sv
verif/coreTb.sv

//--- source/alu.sv
`timescale 1ns/100ps

module alu import mipsPkg::*; (
	input word_t operandA,
	input word_t operandB,
	input aluOp_t op,
	output word_t result
);

	// signed view for slt
	logic signed [31:0] signedA;
	logic signed [31:0] signedB;

	assign signedA = operandA;
	assign signedB = operandB;

	always_comb begin
		case (op)
			// addu, addiu, lw/sw address; no overflow trap
			aluAdd: result = operandA + operandB;
			aluSub: result = operandA - operandB;
			aluAnd: result = operandA & operandB;
			aluOr: result = operandA | operandB;
			// signed compare, 1 or 0
			aluSlt: result = {31'b0, signedA < signedB};
			// immediate into the upper half
			aluLui: result = {operandB[15:0], 16'b0};
			default: result = '0;
		endcase
	end

endmodule

//--- source/controlDecoder.sv
`timescale 1ns/100ps

module controlDecoder import mipsPkg::*; (
	input word_t instrD,
	output ctrl_t ctrlD
);

	logic [5:0] opcode;
	logic [5:0] funct;

	assign opcode = instrD[31:26];
	assign funct = instrD[5:0];

	always_comb begin
		// default is a nop, nothing written anywhere
		ctrlD = '0;
		// canonical nop and bubbles skip the decode entirely
		if (instrD != nopWord) begin
			case (opcode)
				opSpecial: begin
					// r-type, result to rd
					ctrlD.regDst = 1'b1;
					ctrlD.regWrite = 1'b1;
					case (funct)
						fnAddu: ctrlD.aluOp = aluAdd;
						fnSubu: ctrlD.aluOp = aluSub;
						fnAnd: ctrlD.aluOp = aluAnd;
						fnOr: ctrlD.aluOp = aluOr;
						fnSlt: ctrlD.aluOp = aluSlt;
						// unknown funct drops the write again
						default: ctrlD.regWrite = 1'b0;
					endcase
				end
				opAddiu: begin
					ctrlD.regWrite = 1'b1;
					ctrlD.aluSrc = 1'b1;
					ctrlD.aluOp = aluAdd;
				end
				opOri: begin
					ctrlD.regWrite = 1'b1;
					ctrlD.aluSrc = 1'b1;
					ctrlD.zeroExtend = 1'b1;
					ctrlD.aluOp = aluOr;
				end
				opLui: begin
					ctrlD.regWrite = 1'b1;
					ctrlD.aluSrc = 1'b1;
					ctrlD.aluOp = aluLui;
				end
				opLw: begin
					ctrlD.regWrite = 1'b1;
					ctrlD.memToReg = 1'b1;
					ctrlD.aluSrc = 1'b1;
					ctrlD.aluOp = aluAdd;
				end
				opSw: begin
					// address from rs + offset, data from rt
					ctrlD.memWrite = 1'b1;
					ctrlD.aluSrc = 1'b1;
					ctrlD.aluOp = aluAdd;
				end
				opBeq: ctrlD.branch = 1'b1;
				opBne: begin
					ctrlD.branch = 1'b1;
					ctrlD.branchNe = 1'b1;
				end
				opJ: ctrlD.jump = 1'b1;
				default: ctrlD = '0;
			endcase
		end
	end

endmodule

//--- source/datapath.sv
`timescale 1ns/100ps

module datapath import mipsPkg::*; (
	input logic clk,
	input logic reset,
	output word_t pcF,
	input word_t instrF,
	output word_t instrD,
	input ctrl_t ctrlD,
	output logic memWriteM,
	output word_t aluOutM,
	output word_t writeDataM,
	input word_t readDataM,
	output word_t wbPc,
	output logic [3:0] wbWen,
	output regIdx_t wbWnum,
	output word_t wbWdata
);

	// hazard controls
	logic stallF;
	logic stallD;
	logic flushE;
	logic forwardAD;
	logic forwardBD;
	logic [1:0] forwardAE;
	logic [1:0] forwardBE;

	// fetch
	word_t pcPlus4F;
	word_t pcNextF;
	ifId_t ifIdF;

	// decode
	ifId_t ifIdD;
	regIdx_t rsD;
	regIdx_t rtD;
	regIdx_t rdD;
	word_t pcPlus4D;
	word_t signImmD;
	word_t immD;
	word_t branchTargetD;
	word_t jumpTargetD;
	word_t rfDataA;
	word_t rfDataB;
	word_t cmpA;
	word_t cmpB;
	logic takeBranchD;
	idEx_t idExD;

	// execute, memory, writeback
	idEx_t idExE;
	word_t srcAE;
	word_t rtFwdE;
	word_t srcBE;
	word_t aluOutE;
	regIdx_t writeRegE;
	exMem_t exMemE;
	exMem_t exMemM;
	memWb_t memWbM;
	memWb_t memWbW;
	word_t resultW;

	//////////////////////////////
	// fetch
	//////////////////////////////

	assign pcPlus4F = pcF + 32'd4;

	// jump before branch before sequential
	assign pcNextF = ctrlD.jump ? jumpTargetD :
		takeBranchD ? branchTargetD : pcPlus4F;

	always_ff @(posedge clk) begin
		if (reset) begin
			pcF <= resetPc;
		end else if (!stallF) begin
			pcF <= pcNextF;
		end
	end

	assign ifIdF = '{pc: pcF, instr: instrF};

	// no decode flush, the delay slot always runs
	stageReg #(.payload_t(ifId_t)) ifIdReg (
		.clk(clk),
		.reset(reset),
		.enable(!stallD),
		.clear(1'b0),
		.d(ifIdF),
		.q(ifIdD)
	);

	//////////////////////////////
	// decode
	//////////////////////////////

	assign instrD = ifIdD.instr;
	assign rsD = instrD[25:21];
	assign rtD = instrD[20:16];
	assign rdD = instrD[15:11];

	assign pcPlus4D = ifIdD.pc + 32'd4;
	assign signImmD = {{16{instrD[15]}}, instrD[15:0]};
	// ori takes the zero-extended form
	assign immD = ctrlD.zeroExtend ? {16'b0, instrD[15:0]} : signImmD;
	assign branchTargetD = pcPlus4D + {signImmD[29:0], 2'b00};
	assign jumpTargetD = {pcPlus4D[31:28], instrD[25:0], 2'b00};

	// written in writeback, read here
	registerFile regFile (
		.clk(clk),
		.writeEnable(memWbW.regWrite),
		.readAddrA(rsD),
		.readAddrB(rtD),
		.writeAddr(memWbW.writeReg),
		.writeData(resultW),
		.readDataA(rfDataA),
		.readDataB(rfDataB)
	);

	// early compare, writeback already bypassed by the register file
	assign cmpA = forwardAD ? exMemM.aluOut : rfDataA;
	assign cmpB = forwardBD ? exMemM.aluOut : rfDataB;
	assign takeBranchD = ctrlD.branch && ((cmpA == cmpB) != ctrlD.branchNe);

	assign idExD = '{
		regWrite: ctrlD.regWrite,
		memToReg: ctrlD.memToReg,
		memWrite: ctrlD.memWrite,
		aluSrc: ctrlD.aluSrc,
		regDst: ctrlD.regDst,
		aluOp: ctrlD.aluOp,
		pc: ifIdD.pc,
		rsVal: rfDataA,
		rtVal: rfDataB,
		imm: immD,
		rs: rsD,
		rt: rtD,
		rd: rdD
	};

	stageReg #(.payload_t(idEx_t)) idExReg (
		.clk(clk),
		.reset(reset),
		.enable(1'b1),
		.clear(flushE),
		.d(idExD),
		.q(idExE)
	);

	//////////////////////////////
	// execute
	//////////////////////////////

	// 10 from memory, 01 from writeback
	always_comb begin
		case (forwardAE)
			2'b10: srcAE = exMemM.aluOut;
			2'b01: srcAE = resultW;
			default: srcAE = idExE.rsVal;
		endcase
		case (forwardBE)
			2'b10: rtFwdE = exMemM.aluOut;
			2'b01: rtFwdE = resultW;
			default: rtFwdE = idExE.rtVal;
		endcase
	end

	assign srcBE = idExE.aluSrc ? idExE.imm : rtFwdE;
	assign writeRegE = idExE.regDst ? idExE.rd : idExE.rt;

	alu execAlu (
		.operandA(srcAE),
		.operandB(srcBE),
		.op(idExE.aluOp),
		.result(aluOutE)
	);

	assign exMemE = '{
		regWrite: idExE.regWrite,
		memToReg: idExE.memToReg,
		memWrite: idExE.memWrite,
		pc: idExE.pc,
		aluOut: aluOutE,
		writeData: rtFwdE,
		writeReg: writeRegE
	};

	stageReg #(.payload_t(exMem_t)) exMemReg (
		.clk(clk),
		.reset(reset),
		.enable(1'b1),
		.clear(1'b0),
		.d(exMemE),
		.q(exMemM)
	);

	//////////////////////////////
	// memory and writeback
	//////////////////////////////

	// single-cycle port, store lands on the next edge
	assign memWriteM = exMemM.memWrite;
	assign aluOutM = exMemM.aluOut;
	assign writeDataM = exMemM.writeData;

	assign memWbM = '{
		regWrite: exMemM.regWrite,
		memToReg: exMemM.memToReg,
		pc: exMemM.pc,
		aluOut: exMemM.aluOut,
		readData: readDataM,
		writeReg: exMemM.writeReg
	};

	stageReg #(.payload_t(memWb_t)) memWbReg (
		.clk(clk),
		.reset(reset),
		.enable(1'b1),
		.clear(1'b0),
		.d(memWbM),
		.q(memWbW)
	);

	assign resultW = memWbW.memToReg ? memWbW.readData : memWbW.aluOut;

	// commit trace
	assign wbPc = memWbW.pc;
	assign wbWen = {4{memWbW.regWrite}};
	assign wbWnum = memWbW.writeReg;
	assign wbWdata = resultW;

	hazardUnit hazard (
		.rsD(rsD),
		.rtD(rtD),
		.rsE(idExE.rs),
		.rtE(idExE.rt),
		.writeRegE(writeRegE),
		.writeRegM(exMemM.writeReg),
		.writeRegW(memWbW.writeReg),
		.branchD(ctrlD.branch),
		.regWriteE(idExE.regWrite),
		.memToRegE(idExE.memToReg),
		.regWriteM(exMemM.regWrite),
		.memToRegM(exMemM.memToReg),
		.regWriteW(memWbW.regWrite),
		.forwardAD(forwardAD),
		.forwardBD(forwardBD),
		.forwardAE(forwardAE),
		.forwardBE(forwardBE),
		.stallF(stallF),
		.stallD(stallD),
		.flushE(flushE)
	);

endmodule

//--- source/hazardUnit.sv
`timescale 1ns/100ps

module hazardUnit import mipsPkg::*; (
	input regIdx_t rsD,
	input regIdx_t rtD,
	input regIdx_t rsE,
	input regIdx_t rtE,
	input regIdx_t writeRegE,
	input regIdx_t writeRegM,
	input regIdx_t writeRegW,
	input logic branchD,
	input logic regWriteE,
	input logic memToRegE,
	input logic regWriteM,
	input logic memToRegM,
	input logic regWriteW,
	output logic forwardAD,
	output logic forwardBD,
	output logic [1:0] forwardAE,
	output logic [1:0] forwardBE,
	output logic stallF,
	output logic stallD,
	output logic flushE
);

	logic loadUseStall;
	logic branchStall;

	// source matches a pending write, $0 never counts
	function automatic logic hit(regIdx_t src, regIdx_t dst, logic wen);
		return wen && src != '0 && src == dst;
	endfunction

	// branch compare in decode, only memory can feed it
	assign forwardAD = hit(rsD, writeRegM, regWriteM);
	assign forwardBD = hit(rtD, writeRegM, regWriteM);

	// execute operands, memory wins over writeback
	assign forwardAE = hit(rsE, writeRegM, regWriteM) ? 2'b10 :
		hit(rsE, writeRegW, regWriteW) ? 2'b01 : 2'b00;
	assign forwardBE = hit(rtE, writeRegM, regWriteM) ? 2'b10 :
		hit(rtE, writeRegW, regWriteW) ? 2'b01 : 2'b00;

	// load in execute, data not there until writeback
	assign loadUseStall = hit(rsD, writeRegE, memToRegE) || hit(rtD, writeRegE, memToRegE);

	// branch needs a result still in execute, or a load still in memory
	assign branchStall = branchD && (hit(rsD, writeRegE, regWriteE) ||
		hit(rtD, writeRegE, regWriteE) || hit(rsD, writeRegM, memToRegM) ||
		hit(rtD, writeRegM, memToRegM));

	// hold fetch and decode, send a bubble into execute
	assign stallD = loadUseStall || branchStall;
	assign stallF = stallD;
	assign flushE = stallD;

	// every stall flushes execute and waits on a real producer
	always_comb begin
		assert (!stallD || (flushE && (regWriteE || memToRegM)))
			else $error("hazardUnit: stall without flush or producer");
	end

endmodule

//--- source/mipsCore.sv
`timescale 1ns/100ps

module mipsCore import mipsPkg::*; (
	input logic clk,
	input logic reset,
	// instruction port
	output word_t pcF,
	input word_t instrF,
	// data port, no wait states
	output logic memWriteM,
	output word_t aluOutM,
	output word_t writeDataM,
	input word_t readDataM,
	// commit trace
	output word_t wbPc,
	output logic [3:0] wbWen,
	output regIdx_t wbWnum,
	output word_t wbWdata
);

	// decode-stage instruction and its controls
	word_t instrD;
	ctrl_t ctrlD;

	controlDecoder decoder (
		.instrD(instrD),
		.ctrlD(ctrlD)
	);

	datapath dp (
		.clk(clk),
		.reset(reset),
		.pcF(pcF),
		.instrF(instrF),
		.instrD(instrD),
		.ctrlD(ctrlD),
		.memWriteM(memWriteM),
		.aluOutM(aluOutM),
		.writeDataM(writeDataM),
		.readDataM(readDataM),
		.wbPc(wbPc),
		.wbWen(wbWen),
		.wbWnum(wbWnum),
		.wbWdata(wbWdata)
	);

endmodule

//--- source/mipsPkg.sv
package mipsPkg;

	//////////////////////////////
	// basic types
	//////////////////////////////

	// machine word, used for instructions, addresses and data
	typedef logic [31:0] word_t;
	// gpr number
	typedef logic [4:0] regIdx_t;

	// first fetch address
	localparam word_t resetPc = 32'h0000_0000;
	// sll $0,$0,0
	localparam word_t nopWord = 32'h0000_0000;

	// opcodes of the supported subset
	localparam logic [5:0] opSpecial = 6'h00;
	localparam logic [5:0] opJ = 6'h02;
	localparam logic [5:0] opBeq = 6'h04;
	localparam logic [5:0] opBne = 6'h05;
	localparam logic [5:0] opAddiu = 6'h09;
	localparam logic [5:0] opOri = 6'h0d;
	localparam logic [5:0] opLui = 6'h0f;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opSw = 6'h2b;

	// funct field, special opcode only
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnSlt = 6'h2a;

	// alu operations, add is the zero code so a bubble decodes to it
	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt,
		aluLui
	} aluOp_t;

	//////////////////////////////
	// controls and stage payloads
	//////////////////////////////

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic aluSrc;
		logic regDst;
		logic zeroExtend;
		logic branch;
		logic branchNe;
		logic jump;
		aluOp_t aluOp;
	} ctrl_t;

	// fetch to decode
	typedef struct packed {
		word_t pc;
		word_t instr;
	} ifId_t;

	// decode to execute
	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic aluSrc;
		logic regDst;
		aluOp_t aluOp;
		word_t pc;
		word_t rsVal;
		word_t rtVal;
		word_t imm;
		regIdx_t rs;
		regIdx_t rt;
		regIdx_t rd;
	} idEx_t;

	// execute to memory
	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memWrite;
		word_t pc;
		word_t aluOut;
		word_t writeData;
		regIdx_t writeReg;
	} exMem_t;

	// memory to writeback
	typedef struct packed {
		logic regWrite;
		logic memToReg;
		word_t pc;
		word_t aluOut;
		word_t readData;
		regIdx_t writeReg;
	} memWb_t;

endpackage

//--- source/registerFile.sv
`timescale 1ns/100ps

module registerFile import mipsPkg::*; (
	input logic clk,
	input logic writeEnable,
	input regIdx_t readAddrA,
	input regIdx_t readAddrB,
	input regIdx_t writeAddr,
	input word_t writeData,
	output word_t readDataA,
	output word_t readDataB
);

	word_t regs [32];

	// $0 is never stored
	always_ff @(posedge clk) begin
		if (writeEnable && writeAddr != '0) begin
			regs[writeAddr] <= writeData;
		end
	end

	// $0 reads zero, same-cycle write is bypassed to the reader
	assign readDataA = (readAddrA == '0) ? '0 :
		(writeEnable && writeAddr == readAddrA) ? writeData : regs[readAddrA];
	assign readDataB = (readAddrB == '0) ? '0 :
		(writeEnable && writeAddr == readAddrB) ? writeData : regs[readAddrB];

	// a write aimed at $0 leaves its storage untouched
	assert property (@(posedge clk) writeEnable && writeAddr == '0 |=> regs[0] === $past(regs[0]))
		else $error("registerFile: storage of register 0 was written");

endmodule

//--- source/stageReg.sv
`timescale 1ns/100ps

module stageReg import mipsPkg::*; #(
	parameter type payload_t = word_t
) (
	input logic clk,
	input logic reset,
	input logic enable,
	input logic clear,
	input payload_t d,
	output payload_t q
);

	// all-zero payload is a bubble, every control bit low
	always_ff @(posedge clk) begin
		if (reset || clear) begin
			q <= '0;
		end else if (enable) begin
			q <= d;
		end
	end

	// stage must come out of reset empty
	assert property (@(posedge clk) reset |=> q == '0)
		else $error("stageReg: payload not cleared after reset");

endmodule

//--- verif/programTable.svh
//////////////////////////////
// program image
//////////////////////////////

// one word per instruction from resetPc up
localparam int programLen = 29;

localparam word_t programImage [programLen] = '{
	// lui then ori on the same register at distance one
	32'h3C01_1234,
	32'h3421_5678,
	// -5 and 3 for the signed compare
	32'h2402_FFFB,
	32'h2403_0003,
	// slt, subu, and, or, addu
	32'h0043_202A,
	32'h0062_2823,
	32'h0025_3024,
	32'h0022_3825,
	32'h00E4_4021,
	// write to $0 then read it back
	32'h2400_0007,
	32'h0003_4821,
	// sw $1,16($0) then base in $10 and sw $7,4($10)
	32'hAC01_0010,
	32'h240A_0020,
	32'hAD47_0004,
	// load-use pair on lfsr data
	32'h8D4B_0008,
	32'h0160_6021,
	// load feeding a taken beq, delay slot, skipped word
	32'h8C0D_0010,
	32'h11A1_0002,
	32'h240E_0011,
	32'h240F_0099,
	// bne not taken, delay slot, fall-through
	32'h1469_0002,
	32'h2410_0022,
	32'h2411_0033,
	// j 0x68, delay slot, skipped word
	32'h0800_001A,
	32'h2632_0001,
	32'h2413_0044,
	// sw $18,12($10)
	32'hAD52_000C,
	// self-jump with nop in the slot
	32'h0800_001B,
	32'h0000_0000
};

//////////////////////////////
// expected results
//////////////////////////////

// isLoad rows take their value from the memory model at addr
typedef struct packed {
	word_t pc;
	regIdx_t wnum;
	word_t data;
	logic isLoad;
	word_t addr;
} traceRow_t;

typedef struct packed {
	word_t addr;
	word_t data;
} storeRow_t;

localparam int traceLen = 19;
localparam int storeLen = 3;

localparam traceRow_t traceTable [traceLen] = '{
	'{32'h0000_0000, 5'd1, 32'h1234_0000, 1'b0, 32'h0},
	'{32'h0000_0004, 5'd1, 32'h1234_5678, 1'b0, 32'h0},
	'{32'h0000_0008, 5'd2, 32'hFFFF_FFFB, 1'b0, 32'h0},
	'{32'h0000_000C, 5'd3, 32'h0000_0003, 1'b0, 32'h0},
	'{32'h0000_0010, 5'd4, 32'h0000_0001, 1'b0, 32'h0},
	'{32'h0000_0014, 5'd5, 32'h0000_0008, 1'b0, 32'h0},
	'{32'h0000_0018, 5'd6, 32'h0000_0008, 1'b0, 32'h0},
	'{32'h0000_001C, 5'd7, 32'hFFFF_FFFB, 1'b0, 32'h0},
	'{32'h0000_0020, 5'd8, 32'hFFFF_FFFC, 1'b0, 32'h0},
	'{32'h0000_0024, 5'd0, 32'h0000_0007, 1'b0, 32'h0},
	'{32'h0000_0028, 5'd9, 32'h0000_0003, 1'b0, 32'h0},
	'{32'h0000_0030, 5'd10, 32'h0000_0020, 1'b0, 32'h0},
	'{32'h0000_0038, 5'd11, 32'h0, 1'b1, 32'h0000_0028},
	'{32'h0000_003C, 5'd12, 32'h0, 1'b1, 32'h0000_0028},
	'{32'h0000_0040, 5'd13, 32'h0, 1'b1, 32'h0000_0010},
	'{32'h0000_0048, 5'd14, 32'h0000_0011, 1'b0, 32'h0},
	'{32'h0000_0054, 5'd16, 32'h0000_0022, 1'b0, 32'h0},
	'{32'h0000_0058, 5'd17, 32'h0000_0033, 1'b0, 32'h0},
	'{32'h0000_0060, 5'd18, 32'h0000_0034, 1'b0, 32'h0}
};

localparam storeRow_t storeTable [storeLen] = '{
	'{32'h0000_0010, 32'h1234_5678},
	'{32'h0000_0024, 32'hFFFF_FFFB},
	'{32'h0000_002C, 32'h0000_0034}
};

//--- verif/coreTb.sv
`timescale 1ns/100ps

module coreTb import mipsPkg::*; ();

	`include "programTable.svh"

	// eight cycles per expected event plus pipeline fill
	localparam int timeoutCycles = (traceLen + storeLen) * 8 + 20;
	localparam logic [31:0] lfsrSeed = 32'h5d5e_f61e;

	logic clk = 1'b0;
	logic reset;
	word_t pcF;
	word_t instrF;
	logic memWriteM;
	word_t aluOutM;
	word_t writeDataM;
	word_t readDataM;
	word_t wbPc;
	logic [3:0] wbWen;
	regIdx_t wbWnum;
	word_t wbWdata;

	// combinational word memories
	word_t instrMem [64];
	word_t dataMem [64];
	int storeCount;

	mipsCore i_dut (
		.clk(clk),
		.reset(reset),
		.pcF(pcF),
		.instrF(instrF),
		.memWriteM(memWriteM),
		.aluOutM(aluOutM),
		.writeDataM(writeDataM),
		.readDataM(readDataM),
		.wbPc(wbPc),
		.wbWen(wbWen),
		.wbWnum(wbWnum),
		.wbWdata(wbWdata)
	);

	assign instrF = instrMem[pcF[7:2]];
	assign readDataM = dataMem[aluOutM[7:2]];

	always #50 clk = ~clk;

	//////////////////////////////
	// helpers
	//////////////////////////////

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] nextLfsrState(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkWord(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			abortRun($sformatf("Error: %s got 0x%08h, expected 0x%08h", name, got, exp));
		end
	endtask

	task automatic checkReg(input string name, input regIdx_t got, input regIdx_t exp);
		if (got !== exp) begin
			abortRun($sformatf("Error: %s got 0x%02h, expected 0x%02h", name, got, exp));
		end
	endtask

	//////////////////////////////
	// data memory and store check
	//////////////////////////////

	initial begin
		logic [31:0] lfsrState;
		word_t fillWord;
		word_t storeAddr;
		word_t storeData;
		lfsrState = lfsrSeed;
		storeCount = 0;
		// 32 lfsr steps per word with one bit taken per step
		for (int w = 0; w < 64; w++) begin
			fillWord = '0;
			for (int b = 0; b < 32; b++) begin
				lfsrState = nextLfsrState(lfsrState);
				fillWord = {fillWord[30:0], lfsrState[0]};
			end
			dataMem[w] = fillWord;
		end
		forever begin
			// port is stable at the falling edge
			@(negedge clk);
			if (!reset && memWriteM === 1'b1) begin
				if (storeCount >= storeLen) begin
					abortRun("a store was issued beyond the end of the store table");
				end else begin
					storeAddr = aluOutM;
					storeData = writeDataM;
					checkWord("aluOutM", storeAddr, storeTable[storeCount].addr);
					checkWord("writeDataM", storeData, storeTable[storeCount].data);
					// store lands at the rising edge
					@(posedge clk);
					dataMem[storeAddr[7:2]] <= storeData;
					storeCount++;
				end
			end
		end
	end

	//////////////////////////////
	// reset and trace walk
	//////////////////////////////

	initial begin
		int row;
		reset = 1'b1;
		for (int i = 0; i < 64; i++) begin
			if (i < programLen) begin
				instrMem[i] = programImage[i];
			end else begin
				instrMem[i] = nopWord;
			end
		end
		// pipe must stay empty while reset is held
		repeat (4) begin
			@(negedge clk);
			if (wbWen !== 4'h0) begin
				abortRun($sformatf("Error: wbWen got 0x%01h, expected 0x0", wbWen));
			end
			if (memWriteM !== 1'b0) begin
				abortRun($sformatf("Error: memWriteM got 0x%01h, expected 0x0", memWriteM));
			end
			checkWord("pcF", pcF, resetPc);
		end
		reset = 1'b0;
		for (row = 0; row < traceLen; row++) begin
			@(negedge clk);
			while (wbWen === 4'h0) begin
				@(negedge clk);
			end
			if (wbWen !== 4'hf) begin
				abortRun($sformatf("Error: wbWen got 0x%01h, expected 0xf", wbWen));
			end
			checkWord("wbPc", wbPc, traceTable[row].pc);
			checkReg("wbWnum", wbWnum, traceTable[row].wnum);
			// loads compare against the memory model
			if (traceTable[row].isLoad) begin
				checkWord("wbWdata", wbWdata, dataMem[traceTable[row].addr[7:2]]);
			end else begin
				checkWord("wbWdata", wbWdata, traceTable[row].data);
			end
		end
		// nothing more may commit in the self-jump loop
		repeat (8) begin
			@(negedge clk);
			if (wbWen !== 4'h0) begin
				abortRun("a register write was committed after the end of the program");
			end
		end
		if (storeCount != storeLen) begin
			abortRun("fewer stores were seen than the store table holds");
		end else begin
			$display("Result: PASSED");
			$finish;
		end
	end

	// watchdog
	initial begin
		repeat (timeoutCycles) @(posedge clk);
		abortRun("watchdog expired, the trace did not complete");
	end

endmodule
